//--- source/mlpPkg.sv
`default_nettype none

package mlpPkg;

	localparam int wordWidth = 32;
	localparam int fracBits = 13;

	localparam int numInputs = 8;
	localparam int numHidden = 4;
	localparam int numOutputs = 2;

	// one row of eight weights per hidden neuron.
	localparam logic [0:numHidden*numInputs-1][wordWidth-1:0] hiddenWeights = '{
		2841, -1377, 4102, 655, -2290, 3318, 1024, -518,
		-3901, 2207, 1563, -844, 5012, -1739, 296, 1880,
		1445, 3670, -2512, 2093, -612, 788, -4315, 2954,
		612, -925, 3381, 4470, 1208, -2671, 3099, -1450
	};

	localparam logic [0:numHidden-1][wordWidth-1:0] hiddenBias = '{
		-412, 730, -1085, 268
	};

	localparam logic [0:numOutputs*numHidden-1][wordWidth-1:0] outputWeights = '{
		4411, -2380, 3125, 1707,
		-1650, 3892, 2218, -3034
	};

	localparam logic [0:numOutputs-1][wordWidth-1:0] outputBias = '{
		515, -287
	};

	// word addresses on the bus.
	localparam int adrWidth = 4;
	localparam logic [adrWidth-1:0] regInput0 = 4'd0;
	localparam logic [adrWidth-1:0] regLaunch = 4'd8;
	localparam logic [adrWidth-1:0] regDoneCount = 4'd9;
	localparam logic [adrWidth-1:0] regResult0 = 4'd10;

endpackage

`default_nettype wire

//--- source/neuronDot.sv
`timescale 1ns/1ns
`default_nettype none

module neuronDot
	import mlpPkg::*;
#(
	parameter int numInputs = mlpPkg::numInputs,
	parameter int fracBits = mlpPkg::fracBits,
	parameter logic [0:numInputs-1][wordWidth-1:0] weights = '0,
	parameter logic [wordWidth-1:0] bias = '0
)(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire [numInputs-1:0][wordWidth-1:0] inVector,
	output logic outValid,
	output logic [wordWidth-1:0] outWord
);

	localparam int fieldWidth = 16;

	logic [numInputs-1:0][wordWidth-1:0] captured;
	logic [wordWidth-1:0] weighted;
	logic [wordWidth-1:0] sum;
	logic [2:0] validPipe;

	// products and sum wrap at the word width.
	always_comb
	begin
		weighted = bias;
		for (int i = 0; i < numInputs; i++)
		begin
			weighted = weighted + captured[i] * weights[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			captured <= '0;
			sum <= '0;
			outWord <= '0;
			validPipe <= '0;
		end
		else
		begin
			captured <= inVector;
			sum <= weighted;
			// rectifier, then drop the fraction bits.
			if (sum[wordWidth-1])
				outWord <= '0;
			else
				outWord <= {{(wordWidth-fieldWidth){1'b0}},
					sum[fracBits+fieldWidth-1:fracBits]};
			validPipe <= {validPipe[1:0], inValid};
		end
	end

	assign outValid = validPipe[2];

	validLatency: assert property (@(posedge clk)
		!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3)
		|-> outValid == $past(inValid, 3))
		else $error("neuron valid out of step with its input");

endmodule

`default_nettype wire

//--- source/denseLayer.sv
`timescale 1ns/1ns
`default_nettype none

module denseLayer
	import mlpPkg::*;
#(
	parameter int numInputs = mlpPkg::numInputs,
	parameter int numNeurons = mlpPkg::numHidden,
	parameter int fracBits = mlpPkg::fracBits,
	parameter logic [0:numNeurons*numInputs-1][wordWidth-1:0] weights = '0,
	parameter logic [0:numNeurons-1][wordWidth-1:0] biases = '0
)(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire [numInputs-1:0][wordWidth-1:0] inVector,
	output logic outValid,
	output logic [numNeurons-1:0][wordWidth-1:0] outVector
);

	logic [numNeurons-1:0] neuronValid;

	// each neuron takes its own row of the weight table.
	for (genvar n = 0; n < numNeurons; n++)
	begin : gNeuron
		neuronDot #(
			.numInputs(numInputs),
			.fracBits(fracBits),
			.weights(weights[n*numInputs +: numInputs]),
			.bias(biases[n])
		) neuron (
			.clk(clk),
			.reset(reset),
			.inValid(inValid),
			.inVector(inVector),
			.outValid(neuronValid[n]),
			.outWord(outVector[n])
		);
	end

	// all neurons share one timing.
	assign outValid = neuronValid[0];

	neuronsInStep: assert property (@(posedge clk)
		(&neuronValid) || !(|neuronValid))
		else $error("neurons in one layer disagree on valid");

endmodule

`default_nettype wire

//--- source/wbSlave.sv
`timescale 1ns/1ns
`default_nettype none

module wbSlave
	import mlpPkg::*;
#(
	parameter int numInputs = mlpPkg::numInputs,
	parameter int numOutputs = mlpPkg::numOutputs
)(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [adrWidth-1:0] adr,
	input wire [wordWidth-1:0] datWr,
	output logic [wordWidth-1:0] datRd,
	output logic ack,
	output logic launchValid,
	output logic [numInputs-1:0][wordWidth-1:0] launchVector,
	input wire resultValid,
	input wire [numOutputs-1:0][wordWidth-1:0] resultVector
);

	logic [numInputs-1:0][wordWidth-1:0] inputRegs;
	logic [numOutputs-1:0][wordWidth-1:0] resultRegs;
	logic [wordWidth-1:0] doneCount;
	logic [wordWidth-1:0] readData;
	logic request;

	// new cycle seen, not yet answered.
	assign request = cyc && stb && !ack;

	always_comb
	begin
		readData = '0;
		for (int i = 0; i < numInputs; i++)
		begin
			if (adr == adrWidth'(regInput0 + i))
				readData = inputRegs[i];
		end
		for (int i = 0; i < numOutputs; i++)
		begin
			if (adr == adrWidth'(regResult0 + i))
				readData = resultRegs[i];
		end
		if (adr == regDoneCount)
			readData = doneCount;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			datRd <= '0;
			launchValid <= 1'b0;
			inputRegs <= '0;
			resultRegs <= '0;
			doneCount <= '0;
		end
		else
		begin
			ack <= request;
			datRd <= (request && !we) ? readData : '0;
			launchValid <= request && we && adr == regLaunch;
			if (request && we)
			begin
				for (int i = 0; i < numInputs; i++)
				begin
					if (adr == adrWidth'(regInput0 + i))
						inputRegs[i] <= datWr;
				end
			end
			// only the latest result is kept.
			if (resultValid)
			begin
				resultRegs <= resultVector;
				doneCount <= doneCount + 1'b1;
			end
		end
	end

	assign launchVector = inputRegs;

	ackFollowsRequest: assert property (@(posedge clk) disable iff (reset)
		ack |-> $past(cyc && stb))
		else $error("ack without a bus request");

	ackSingleCycle: assert property (@(posedge clk) disable iff (reset)
		ack |=> !ack)
		else $error("ack held for two cycles");

endmodule

`default_nettype wire

//--- source/mlpTop.sv
`timescale 1ns/1ns
`default_nettype none

module mlpTop
	import mlpPkg::*;
#(
	parameter int numInputs = mlpPkg::numInputs,
	parameter int numHidden = mlpPkg::numHidden,
	parameter int numOutputs = mlpPkg::numOutputs,
	parameter logic [0:numHidden*numInputs-1][wordWidth-1:0] hiddenWeights =
		mlpPkg::hiddenWeights,
	parameter logic [0:numHidden-1][wordWidth-1:0] hiddenBias = mlpPkg::hiddenBias,
	parameter logic [0:numOutputs*numHidden-1][wordWidth-1:0] outputWeights =
		mlpPkg::outputWeights,
	parameter logic [0:numOutputs-1][wordWidth-1:0] outputBias = mlpPkg::outputBias
)(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [adrWidth-1:0] adr,
	input wire [wordWidth-1:0] datWr,
	output logic [wordWidth-1:0] datRd,
	output logic ack
);

	logic launchValid;
	logic [numInputs-1:0][wordWidth-1:0] launchVector;
	logic hiddenValid;
	logic [numHidden-1:0][wordWidth-1:0] hiddenVector;
	logic resultValid;
	logic [numOutputs-1:0][wordWidth-1:0] resultVector;

	wbSlave #(
		.numInputs(numInputs),
		.numOutputs(numOutputs)
	) bus (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWr(datWr),
		.datRd(datRd),
		.ack(ack),
		.launchValid(launchValid),
		.launchVector(launchVector),
		.resultValid(resultValid),
		.resultVector(resultVector)
	);

	denseLayer #(
		.numInputs(numInputs),
		.numNeurons(numHidden),
		.fracBits(fracBits),
		.weights(hiddenWeights),
		.biases(hiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(launchValid),
		.inVector(launchVector),
		.outValid(hiddenValid),
		.outVector(hiddenVector)
	);

	// second layer sees the hidden outputs as its inputs.
	denseLayer #(
		.numInputs(numHidden),
		.numNeurons(numOutputs),
		.fracBits(fracBits),
		.weights(outputWeights),
		.biases(outputBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inVector(hiddenVector),
		.outValid(resultValid),
		.outVector(resultVector)
	);

endmodule

`default_nettype wire

//--- dv/mlpModel.svh
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// fibonacci lfsr with taps 32 22 2 1.
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// zero for a negative sum, else the 16-bit field above the fraction.
function automatic logic [wordWidth-1:0] rectifyWord(input logic [wordWidth-1:0] sum);
	if (sum[wordWidth-1])
		return '0;
	return {16'b0, sum[fracBits+15:fracBits]};
endfunction

// both layers in 32-bit wrapped arithmetic.
function automatic logic [numOutputs-1:0][wordWidth-1:0] referenceInference(
	input logic [numInputs-1:0][wordWidth-1:0] inputs);
	logic [numHidden-1:0][wordWidth-1:0] hidden;
	logic [numOutputs-1:0][wordWidth-1:0] results;
	logic [wordWidth-1:0] acc;
	for (int n = 0; n < numHidden; n++)
	begin
		acc = hiddenBias[n];
		for (int i = 0; i < numInputs; i++)
			acc = acc + inputs[i] * hiddenWeights[n*numInputs + i];
		hidden[n] = rectifyWord(acc);
	end
	for (int n = 0; n < numOutputs; n++)
	begin
		acc = outputBias[n];
		for (int i = 0; i < numHidden; i++)
			acc = acc + hidden[i] * outputWeights[n*numHidden + i];
		results[n] = rectifyWord(acc);
	end
	return results;
endfunction

`endif

//--- dv/mlpTb.sv
`timescale 1ns/1ns
`default_nettype none

module mlpTb
	import mlpPkg::*;
();

	`include "mlpModel.svh"

	// tests need roughly 6500 cycles.
	localparam int cycleLimit = 20000;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [adrWidth-1:0] adr;
	logic [wordWidth-1:0] datWr;
	logic [wordWidth-1:0] datRd;
	logic ack;

	logic [31:0] lfsrState = 32'h9e1413d8;
	logic [wordWidth-1:0] doneTotal = '0;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int otherErrors = 0;

	string nameQueue[$];
	logic [wordWidth-1:0] expectedQueue[$];
	logic [wordWidth-1:0] actualQueue[$];

	mlpTop dut (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWr(datWr),
		.datRd(datRd),
		.ack(ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [wordWidth-1:0] randomBits(input int count);
		logic [wordWidth-1:0] value;
		value = '0;
		for (int b = 0; b < count; b++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[wordWidth-2:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic checkValue(input string name, input logic [wordWidth-1:0] expected,
		input logic [wordWidth-1:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic postCheck(input string name, input logic [wordWidth-1:0] expected,
		input logic [wordWidth-1:0] actual);
		nameQueue.push_back(name);
		expectedQueue.push_back(expected);
		actualQueue.push_back(actual);
	endtask

	// compare process drains whatever the tests posted.
	always @(posedge clk)
	begin
		while (actualQueue.size() > 0)
			checkValue(nameQueue.pop_front(), expectedQueue.pop_front(),
				actualQueue.pop_front());
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: no verdict after %0d cycles", cycleCount);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic wbWrite(input logic [adrWidth-1:0] address, input logic [wordWidth-1:0] data);
		int waited;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = address;
		datWr = data;
		waited = 1;
		@(negedge clk);
		while (!ack && waited < 4)
		begin
			@(negedge clk);
			waited++;
		end
		if (!ack)
		begin
			$display("write to address %0d got no ack within 4 cycles", address);
			otherErrors++;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wbRead(input logic [adrWidth-1:0] address, output logic [wordWidth-1:0] data);
		int waited;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = address;
		waited = 1;
		@(negedge clk);
		while (!ack && waited < 4)
		begin
			@(negedge clk);
			waited++;
		end
		if (!ack)
		begin
			$display("read of address %0d got no ack within 4 cycles", address);
			otherErrors++;
		end
		data = datRd;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic waitForCount(input logic [wordWidth-1:0] target,
		output logic [wordWidth-1:0] seen);
		int polls;
		polls = 0;
		wbRead(regDoneCount, seen);
		while (seen != target && polls < 16)
		begin
			wbRead(regDoneCount, seen);
			polls++;
		end
	endtask

	task automatic loadVector(input logic [numInputs-1:0][wordWidth-1:0] vec);
		for (int k = 0; k < numInputs; k++)
			wbWrite(adrWidth'(regInput0 + k), vec[k]);
	endtask

	task automatic compareResults(input string name,
		input logic [numInputs-1:0][wordWidth-1:0] vec);
		logic [numOutputs-1:0][wordWidth-1:0] expected;
		logic [wordWidth-1:0] data;
		expected = referenceInference(vec);
		for (int k = 0; k < numOutputs; k++)
		begin
			wbRead(adrWidth'(regResult0 + k), data);
			postCheck($sformatf("%s result%0d", name, k), expected[k], data);
		end
	endtask

	task automatic runVector(input string name, input logic [numInputs-1:0][wordWidth-1:0] vec);
		logic [wordWidth-1:0] seen;
		loadVector(vec);
		wbWrite(regLaunch, 32'd1);
		doneTotal = doneTotal + 32'd1;
		waitForCount(doneTotal, seen);
		postCheck({name, " doneCount"}, doneTotal, seen);
		compareResults(name, vec);
	endtask

	task automatic resetValueTest();
		logic [wordWidth-1:0] data;
		wbRead(regDoneCount, data);
		postCheck("reset doneCount", '0, data);
		for (int k = 0; k < numOutputs; k++)
		begin
			wbRead(adrWidth'(regResult0 + k), data);
			postCheck($sformatf("reset result%0d", k), '0, data);
		end
		for (int k = 0; k < numInputs; k++)
		begin
			wbRead(adrWidth'(regInput0 + k), data);
			postCheck($sformatf("reset input%0d", k), '0, data);
		end
	endtask

	task automatic registerAccessTest();
		logic [wordWidth-1:0] data;
		logic [wordWidth-1:0] pattern;
		for (int k = 0; k < numInputs; k++)
		begin
			pattern = 32'h3c1f_5a00 ^ (k * 32'h0102_0401);
			wbWrite(adrWidth'(regInput0 + k), pattern);
			wbRead(adrWidth'(regInput0 + k), data);
			postCheck($sformatf("readback input%0d", k), pattern, data);
		end
		// 12 to 15 are not mapped.
		for (int a = 12; a < 16; a++)
		begin
			wbWrite(adrWidth'(a), 32'hffff_ffff);
			wbRead(adrWidth'(a), data);
			postCheck($sformatf("unmapped address %0d", a), '0, data);
		end
		// unmapped writes leave the inputs alone.
		for (int k = 0; k < numInputs; k++)
		begin
			pattern = 32'h3c1f_5a00 ^ (k * 32'h0102_0401);
			wbRead(adrWidth'(regInput0 + k), data);
			postCheck($sformatf("input%0d after unmapped writes", k), pattern, data);
		end
	endtask

	task automatic backToBackTest();
		logic [numInputs-1:0][wordWidth-1:0] vecA;
		logic [numInputs-1:0][wordWidth-1:0] vecB;
		logic [wordWidth-1:0] seen;
		for (int k = 0; k < numInputs; k++)
		begin
			vecA[k] = 32'd1000 * (k + 1);
			vecB[k] = 32'd2500 + 32'd700 * k;
		end
		loadVector(vecA);
		wbWrite(regLaunch, 32'd1);
		loadVector(vecB);
		wbWrite(regLaunch, 32'd1);
		doneTotal = doneTotal + 32'd2;
		waitForCount(doneTotal, seen);
		// no third result may show up later.
		repeat (12) @(negedge clk);
		wbRead(regDoneCount, seen);
		postCheck("back-to-back doneCount", doneTotal, seen);
		compareResults("back-to-back", vecB);
	endtask

	initial
	begin
		logic [numInputs-1:0][wordWidth-1:0] vec;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datWr = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		resetValueTest();
		registerAccessTest();

		runVector("zeros", '0);
		vec = '0;
		vec[1] = 32'd10000;
		runVector("negative hidden", vec);
		for (int k = 0; k < numInputs; k++)
			vec[k] = 32'h0fff_ffff - k;
		runVector("wrap", vec);

		for (int r = 0; r < 200; r++)
		begin
			for (int k = 0; k < numInputs; k++)
				vec[k] = randomBits(14);
			runVector($sformatf("random %0d", r), vec);
		end

		backToBackTest();

		repeat (2) @(negedge clk);
		$display("checks %0d, value errors %0d, other errors %0d",
			checkCount, errorCount, otherErrors);
		if (errorCount == 0 && otherErrors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
source/mlpPkg.sv
source/neuronDot.sv
source/denseLayer.sv
source/wbSlave.sv
source/mlpTop.sv
dv/mlpTb.sv

//--- Makefile
# Verilator build and run of the MLP testbench.

VERILATOR ?= verilator
TOP ?= mlpTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
FAIL_TEXT ?= RESULT: FAIL
PASS_TEXT ?= RESULT: PASS

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a verdict"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
